/* design/core_ctrl_pkg.sv */
package core_ctrl_pkg;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B,
        ALU_CMP_EQ
    } alu_op_e;

    // Operand source for execute
    typedef logic [1:0] fwd_sel_t;

    localparam fwd_sel_t FWD_REG = 2'd0;
    localparam fwd_sel_t FWD_MEM = 2'd1;
    localparam fwd_sel_t FWD_WB  = 2'd2;

    // Access size and signedness
    typedef logic [1:0] access_t;

    localparam access_t ACC_WORD   = 2'd0;
    localparam access_t ACC_BYTE   = 2'd1;
    localparam access_t ACC_BYTE_U = 2'd2;

endpackage

/* design/execute.sv */
`timescale 1ns/100ps

module execute (
    input  core_ctrl_pkg::alu_op_e  alu_op,
    input  core_ctrl_pkg::fwd_sel_t fwd_a,
    input  core_ctrl_pkg::fwd_sel_t fwd_b,
    input  logic                    src_a_pc,
    input  logic                    src_b_imm,
    input  riscv_isa_pkg::word_t    rs1_val,
    input  riscv_isa_pkg::word_t    rs2_val,
    input  riscv_isa_pkg::word_t    mem_val,
    input  riscv_isa_pkg::word_t    wb_val,
    input  riscv_isa_pkg::word_t    pc,
    input  riscv_isa_pkg::word_t    imm,
    input  logic                    bra,
    input  logic                    jmp,
    output riscv_isa_pkg::word_t    alu_out,
    output riscv_isa_pkg::word_t    store_val,
    output riscv_isa_pkg::word_t    target,
    output logic                    redirect
);

    riscv_isa_pkg::word_t rs1_fwd;
    riscv_isa_pkg::word_t rs2_fwd;
    riscv_isa_pkg::word_t op_a;
    riscv_isa_pkg::word_t op_b;

    always_comb begin
        case (fwd_a)
            core_ctrl_pkg::FWD_MEM: rs1_fwd = mem_val;
            core_ctrl_pkg::FWD_WB:  rs1_fwd = wb_val;
            default:                rs1_fwd = rs1_val;
        endcase
        case (fwd_b)
            core_ctrl_pkg::FWD_MEM: rs2_fwd = mem_val;
            core_ctrl_pkg::FWD_WB:  rs2_fwd = wb_val;
            default:                rs2_fwd = rs2_val;
        endcase
    end

    assign store_val = rs2_fwd;
    assign op_a      = src_a_pc ? pc : rs1_fwd;
    // JAL link value is pc + 4
    assign op_b      = jmp ? 32'd4 : (src_b_imm ? imm : rs2_fwd);

    always_comb begin
        case (alu_op)
            core_ctrl_pkg::ALU_SUB:    alu_out = op_a - op_b;
            core_ctrl_pkg::ALU_AND:    alu_out = op_a & op_b;
            core_ctrl_pkg::ALU_OR:     alu_out = op_a | op_b;
            core_ctrl_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            core_ctrl_pkg::ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            core_ctrl_pkg::ALU_SLL:    alu_out = op_a << op_b[4:0];
            core_ctrl_pkg::ALU_SRL:    alu_out = op_a >> op_b[4:0];
            core_ctrl_pkg::ALU_PASS_B: alu_out = op_b;
            core_ctrl_pkg::ALU_CMP_EQ: alu_out = {31'b0, op_a == op_b};
            default:                   alu_out = op_a + op_b;
        endcase
    end

    assign target   = pc + imm;
    assign redirect = jmp || (bra && (alu_out != '0));

endmodule

/* design/fetch_decode.sv */
`timescale 1ns/100ps

module fetch_decode (
    input  logic                   clk,
    input  logic                   arst_n,
    input  riscv_isa_pkg::word_t   instr,
    input  logic                   if_valid,
    output riscv_isa_pkg::word_t   imm,
    output core_ctrl_pkg::alu_op_e alu_op,
    output logic                   src_a_pc,
    output logic                   src_b_imm,
    output logic                   mem_w,
    output logic                   reg_w,
    output logic                   mem2reg,
    output logic                   bra,
    output logic                   jmp,
    output core_ctrl_pkg::access_t access
);

    riscv_isa_pkg::opcode_t opcode;
    logic [2:0]             funct3;
    logic                   writes_rd;
    logic                   known_op;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // Writes to x0 are dropped here
    assign reg_w = writes_rd && (instr[11:7] != riscv_isa_pkg::REG_ZERO);

    always_comb begin
        imm       = {{20{instr[31]}}, instr[31:20]};
        alu_op    = core_ctrl_pkg::ALU_ADD;
        src_a_pc  = 1'b0;
        src_b_imm = 1'b0;
        mem_w     = 1'b0;
        writes_rd = 1'b0;
        mem2reg   = 1'b0;
        bra       = 1'b0;
        jmp       = 1'b0;
        access    = core_ctrl_pkg::ACC_WORD;
        known_op  = 1'b1;
        case (opcode)
            riscv_isa_pkg::OP_REG: begin
                writes_rd = 1'b1;
                case (funct3)
                    3'b000:  alu_op = instr[30] ? core_ctrl_pkg::ALU_SUB : core_ctrl_pkg::ALU_ADD;
                    3'b001:  alu_op = core_ctrl_pkg::ALU_SLL;
                    3'b010:  alu_op = core_ctrl_pkg::ALU_SLT;
                    3'b100:  alu_op = core_ctrl_pkg::ALU_XOR;
                    3'b101:  alu_op = core_ctrl_pkg::ALU_SRL;
                    3'b110:  alu_op = core_ctrl_pkg::ALU_OR;
                    3'b111:  alu_op = core_ctrl_pkg::ALU_AND;
                    default: alu_op = core_ctrl_pkg::ALU_ADD;
                endcase
            end
            riscv_isa_pkg::OP_IMM: begin
                src_b_imm = 1'b1;
                writes_rd = 1'b1;
            end
            riscv_isa_pkg::OP_LUI: begin
                imm       = {instr[31:12], 12'b0};
                alu_op    = core_ctrl_pkg::ALU_PASS_B;
                src_b_imm = 1'b1;
                writes_rd = 1'b1;
            end
            riscv_isa_pkg::OP_LOAD: begin
                src_b_imm = 1'b1;
                writes_rd = 1'b1;
                mem2reg   = 1'b1;
                if (funct3 == riscv_isa_pkg::F3_BYTE)
                    access = core_ctrl_pkg::ACC_BYTE;
                else if (funct3 == riscv_isa_pkg::F3_BYTE_U)
                    access = core_ctrl_pkg::ACC_BYTE_U;
            end
            riscv_isa_pkg::OP_STORE: begin
                imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                src_b_imm = 1'b1;
                mem_w     = 1'b1;
                if (funct3 == riscv_isa_pkg::F3_BYTE)
                    access = core_ctrl_pkg::ACC_BYTE;
            end
            riscv_isa_pkg::OP_BRANCH: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                bra = 1'b1;
                // BNE taken when the XOR is nonzero
                alu_op = (funct3 == riscv_isa_pkg::F3_BNE) ? core_ctrl_pkg::ALU_XOR
                                                           : core_ctrl_pkg::ALU_CMP_EQ;
            end
            riscv_isa_pkg::OP_JAL: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
                jmp       = 1'b1;
                src_a_pc  = 1'b1;
                writes_rd = 1'b1;
            end
            default: known_op = 1'b0;
        endcase
    end

    a_known_opcode: assert property (@(posedge clk) disable iff (!arst_n)
        if_valid |-> known_op)
        else $error("unknown opcode %b fetched", opcode);

endmodule

/* design/hazard_unit.sv */
`timescale 1ns/100ps

module hazard_unit (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     mem_reg_w,
    input  logic                     wb_reg_w,
    input  logic                     exec_mem2reg,
    input  logic                     redirect,
    input  logic                     if_valid,
    input  logic                     mem_valid,
    input  riscv_isa_pkg::reg_addr_t ex_rs1,
    input  riscv_isa_pkg::reg_addr_t ex_rs2,
    input  riscv_isa_pkg::reg_addr_t mem_rd,
    input  riscv_isa_pkg::reg_addr_t wb_rd,
    input  riscv_isa_pkg::reg_addr_t ex_rd,
    input  riscv_isa_pkg::reg_addr_t id_rs1,
    input  riscv_isa_pkg::reg_addr_t id_rs2,
    output core_ctrl_pkg::fwd_sel_t  fwd_a,
    output core_ctrl_pkg::fwd_sel_t  fwd_b,
    output logic                     fetch_stall,
    output logic                     exec_bubble,
    output logic                     exec_flush,
    output logic                     freeze
);

    logic load_use;

    // Youngest producer wins
    assign fwd_a = (mem_reg_w && mem_rd == ex_rs1) ? core_ctrl_pkg::FWD_MEM :
                   (wb_reg_w && wb_rd == ex_rs1)   ? core_ctrl_pkg::FWD_WB  :
                                                     core_ctrl_pkg::FWD_REG;
    assign fwd_b = (mem_reg_w && mem_rd == ex_rs2) ? core_ctrl_pkg::FWD_MEM :
                   (wb_reg_w && wb_rd == ex_rs2)   ? core_ctrl_pkg::FWD_WB  :
                                                     core_ctrl_pkg::FWD_REG;

    assign load_use = exec_mem2reg && (ex_rd == id_rs1 || ex_rd == id_rs2);

    assign freeze      = !mem_valid;
    // A redirect discards the fetched word, so stalls on it are moot
    assign exec_flush  = redirect;
    assign exec_bubble = !redirect && (load_use || !if_valid);
    assign fetch_stall = freeze || exec_bubble;

    // The word fetched behind a taken branch never reaches execute
    a_redirect_flushes: assert property (@(posedge clk) disable iff (!arst_n)
        (redirect && mem_valid) |=> !redirect)
        else $error("instruction behind a redirect reached execute");

endmodule

/* design/lsu_align.sv */
`timescale 1ns/100ps

module lsu_align (
    input  logic                   clk,
    input  logic                   arst_n,
    input  core_ctrl_pkg::access_t access_m,
    input  core_ctrl_pkg::access_t access_w,
    input  logic [1:0]             addr_lo_m,
    input  logic [1:0]             addr_lo_w,
    input  riscv_isa_pkg::word_t   store_val,
    input  riscv_isa_pkg::word_t   data_in,
    output riscv_isa_pkg::word_t   data_out,
    output logic [3:0]             data_be,
    output riscv_isa_pkg::word_t   load_val
);

    logic [7:0] load_byte;

    // Byte stores go out on every lane
    assign data_out = (access_m == core_ctrl_pkg::ACC_WORD) ? store_val : {4{store_val[7:0]}};
    assign data_be  = (access_m == core_ctrl_pkg::ACC_WORD) ? 4'b1111 : 4'b0001 << addr_lo_m;

    assign load_byte = data_in[8*addr_lo_w +: 8];

    always_comb begin
        case (access_w)
            core_ctrl_pkg::ACC_BYTE:   load_val = {{24{load_byte[7]}}, load_byte};
            core_ctrl_pkg::ACC_BYTE_U: load_val = {24'b0, load_byte};
            default:                   load_val = data_in;
        endcase
    end

    // Writeback takes the memory-stage access or holds its own
    a_load_lane_follows: assert property (@(posedge clk) disable iff (!arst_n)
        ({access_w, addr_lo_w} == $past({access_m, addr_lo_m}))
            || ({access_w, addr_lo_w} == $past({access_w, addr_lo_w})))
        else $error("writeback access does not follow the memory stage");

endmodule

/* design/pineapple_core.sv */
`timescale 1ns/100ps

module pineapple_core (
    input  logic                 clk,
    input  logic                 arst_n,
    input  riscv_isa_pkg::word_t instr,
    input  logic                 if_valid,
    output riscv_isa_pkg::word_t pc_out,
    input  riscv_isa_pkg::word_t data_in,
    input  logic                 mem_valid,
    output riscv_isa_pkg::word_t data_addr,
    output riscv_isa_pkg::word_t data_out,
    output logic                 data_we,
    output logic [3:0]           data_be
);

    riscv_isa_pkg::word_t     regs [32];
    riscv_isa_pkg::reg_addr_t id_rs1, id_rs2, id_rd;
    riscv_isa_pkg::word_t     id_rs1_val, id_rs2_val, id_imm;
    core_ctrl_pkg::alu_op_e   id_alu_op;
    core_ctrl_pkg::access_t   id_access;
    logic id_src_a_pc, id_src_b_imm, id_mem_w, id_reg_w, id_mem2reg, id_bra, id_jmp;

    // Execute stage
    riscv_isa_pkg::word_t     ex_pc, ex_imm, ex_rs1_val, ex_rs2_val;
    riscv_isa_pkg::reg_addr_t ex_rs1, ex_rs2, ex_rd;
    core_ctrl_pkg::alu_op_e   ex_alu_op;
    core_ctrl_pkg::access_t   ex_access;
    logic ex_src_a_pc, ex_src_b_imm, ex_mem_w, ex_reg_w, ex_mem2reg, ex_bra, ex_jmp;

    // Memory stage
    riscv_isa_pkg::word_t     m_alu, m_store;
    riscv_isa_pkg::reg_addr_t m_rd;
    core_ctrl_pkg::access_t   m_access;
    logic                     m_mem_w, m_reg_w, m_mem2reg;

    // Writeback stage
    riscv_isa_pkg::word_t     w_alu, w_rdata, wb_val, load_val;
    riscv_isa_pkg::reg_addr_t w_rd;
    core_ctrl_pkg::access_t   w_access;
    logic [1:0]               w_addr_lo;
    logic                     w_reg_w, w_mem2reg;

    riscv_isa_pkg::word_t     pc, alu_out, store_val, target;
    core_ctrl_pkg::fwd_sel_t  fwd_a, fwd_b;
    logic [3:0]               lane_be;
    logic redirect, fetch_stall, exec_bubble, exec_flush, freeze;

    assign id_rs1 = instr[19:15];
    assign id_rs2 = instr[24:20];
    assign id_rd  = instr[11:7];
    assign wb_val = w_mem2reg ? load_val : w_alu;

    // Register read sees the result retiring this cycle
    assign id_rs1_val = (id_rs1 == riscv_isa_pkg::REG_ZERO) ? '0 :
                        (w_reg_w && w_rd == id_rs1) ? wb_val : regs[id_rs1];
    assign id_rs2_val = (id_rs2 == riscv_isa_pkg::REG_ZERO) ? '0 :
                        (w_reg_w && w_rd == id_rs2) ? wb_val : regs[id_rs2];

    fetch_decode fetch_decode0 (
        .clk(clk), .arst_n(arst_n), .instr(instr), .if_valid(if_valid),
        .imm(id_imm), .alu_op(id_alu_op), .src_a_pc(id_src_a_pc), .src_b_imm(id_src_b_imm),
        .mem_w(id_mem_w), .reg_w(id_reg_w), .mem2reg(id_mem2reg), .bra(id_bra),
        .jmp(id_jmp), .access(id_access)
    );

    execute execute0 (
        .alu_op(ex_alu_op), .fwd_a(fwd_a), .fwd_b(fwd_b), .src_a_pc(ex_src_a_pc),
        .src_b_imm(ex_src_b_imm), .rs1_val(ex_rs1_val), .rs2_val(ex_rs2_val),
        .mem_val(m_alu), .wb_val(wb_val), .pc(ex_pc), .imm(ex_imm), .bra(ex_bra),
        .jmp(ex_jmp), .alu_out(alu_out), .store_val(store_val), .target(target),
        .redirect(redirect)
    );

    hazard_unit hazard_unit0 (
        .clk(clk), .arst_n(arst_n), .mem_reg_w(m_reg_w), .wb_reg_w(w_reg_w),
        .exec_mem2reg(ex_mem2reg), .redirect(redirect), .if_valid(if_valid),
        .mem_valid(mem_valid), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .mem_rd(m_rd),
        .wb_rd(w_rd), .ex_rd(ex_rd), .id_rs1(id_rs1), .id_rs2(id_rs2), .fwd_a(fwd_a),
        .fwd_b(fwd_b), .fetch_stall(fetch_stall), .exec_bubble(exec_bubble),
        .exec_flush(exec_flush), .freeze(freeze)
    );

    lsu_align lsu_align0 (
        .clk(clk), .arst_n(arst_n), .access_m(m_access), .access_w(w_access),
        .addr_lo_m(m_alu[1:0]), .addr_lo_w(w_addr_lo), .store_val(m_store),
        .data_in(w_rdata), .data_out(data_out), .data_be(lane_be), .load_val(load_val)
    );

    always_ff @(posedge clk) begin
        if (w_reg_w && !freeze)
            regs[w_rd] <= wb_val;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            pc <= '0;
        else if (!fetch_stall)
            pc <= redirect ? target : pc + 32'd4;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_pc <= '0;
            ex_imm <= '0;
            ex_rs1_val <= '0;
            ex_rs2_val <= '0;
            ex_rs1 <= '0;
            ex_rs2 <= '0;
            ex_rd <= '0;
            ex_alu_op <= core_ctrl_pkg::ALU_ADD;
            ex_access <= core_ctrl_pkg::ACC_WORD;
            ex_src_a_pc <= 1'b0;
            ex_src_b_imm <= 1'b0;
            ex_mem_w <= 1'b0;
            ex_reg_w <= 1'b0;
            ex_mem2reg <= 1'b0;
            ex_bra <= 1'b0;
            ex_jmp <= 1'b0;
            m_alu <= '0;
            m_store <= '0;
            m_rd <= '0;
            m_access <= core_ctrl_pkg::ACC_WORD;
            m_mem_w <= 1'b0;
            m_reg_w <= 1'b0;
            m_mem2reg <= 1'b0;
            w_alu <= '0;
            w_rdata <= '0;
            w_rd <= '0;
            w_access <= core_ctrl_pkg::ACC_WORD;
            w_addr_lo <= '0;
            w_reg_w <= 1'b0;
            w_mem2reg <= 1'b0;
        end else if (!freeze) begin
            ex_pc <= pc;
            ex_imm <= id_imm;
            ex_rs1_val <= id_rs1_val;
            ex_rs2_val <= id_rs2_val;
            ex_rs1 <= id_rs1;
            ex_rs2 <= id_rs2;
            ex_rd <= id_rd;
            ex_alu_op <= id_alu_op;
            ex_access <= id_access;
            ex_src_a_pc <= id_src_a_pc;
            ex_src_b_imm <= id_src_b_imm;
            // Bubble clears only the bits that have side effects
            ex_mem_w <= id_mem_w && !(exec_flush || exec_bubble);
            ex_reg_w <= id_reg_w && !(exec_flush || exec_bubble);
            ex_mem2reg <= id_mem2reg && !(exec_flush || exec_bubble);
            ex_bra <= id_bra && !(exec_flush || exec_bubble);
            ex_jmp <= id_jmp && !(exec_flush || exec_bubble);
            m_alu <= alu_out;
            m_store <= store_val;
            m_rd <= ex_rd;
            m_access <= ex_access;
            m_mem_w <= ex_mem_w;
            m_reg_w <= ex_reg_w;
            m_mem2reg <= ex_mem2reg;
            w_alu <= m_alu;
            w_rdata <= data_in;
            w_rd <= m_rd;
            w_access <= m_access;
            w_addr_lo <= m_alu[1:0];
            w_reg_w <= m_reg_w;
            w_mem2reg <= m_mem2reg;
        end
    end

    assign pc_out    = pc;
    assign data_addr = m_alu;
    // Store fires once, in the cycle the data side accepts it
    assign data_we   = m_mem_w && mem_valid;
    assign data_be   = (m_mem_w || m_mem2reg) ? lane_be : 4'b0000;

endmodule

/* design/riscv_isa_pkg.sv */
package riscv_isa_pkg;

    // Words and register indices
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;

    // Major opcodes of the supported subset
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;

    // Load/store sizes
    localparam logic [2:0] F3_BYTE   = 3'b000;
    localparam logic [2:0] F3_WORD   = 3'b010;
    localparam logic [2:0] F3_BYTE_U = 3'b100;

    // Branch compares
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // Hardwired zero register
    localparam reg_addr_t REG_ZERO = 5'd0;

endpackage

/* pineapple_core.f */
design/riscv_isa_pkg.sv
design/core_ctrl_pkg.sv
design/fetch_decode.sv
design/execute.sv
design/hazard_unit.sv
design/lsu_align.sv
design/pineapple_core.sv
tests/tb_pineapple_core.sv

/* run_sim.sh */
#!/bin/bash
set -o pipefail
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f pineapple_core.f \
        --top-module tb_pineapple_core -o sim_tb \
    && ./obj_dir/sim_tb 2>&1 | tee sim.log \
    && ! grep -q "TB FAILED" sim.log \
    || { echo "Simulation did not pass"; exit 1; }

/* tests/program_stim.txt */
// Words 0x00-0x3f: program, one instruction per word, zero past its end
// Word 0x40: store count, then one store per line as address and data
@00
12300093 FBB00113 002081B3 04302023
40208233 003242B3 0012E333 002373B3
04702223 00112433 008094B3 00815533
ABCDE5B7 00958633 04C02423 04A02623
042008A3 05002683 04D02A23 05100703
00170793 04F02C23 05104803 05002E23
00500013 06002023 00108463 06102223
00109463 06102223 00209463 06202423
00208463 008008EF 06202423 07102423
@40
0000000B
00000040 000000DE
00000044 000001B3
00000048 ABCDE246
0000004C 7FFFFFDD
00000051 BBBBBBBB
00000054 C0DEBB50
00000058 FFFFFFBC
0000005C 000000BB
00000060 00000000
00000064 00000123
00000068 00000088

/* tests/tb_pineapple_core.sv */
`timescale 1ns/100ps

module tb_pineapple_core;

    localparam int IMEM_WORDS = 64;
    localparam int EXP_BASE   = 64;
    localparam riscv_isa_pkg::word_t NOP = 32'h0000_0013;

    logic                 clk = 1'b0;
    logic                 arst_n = 1'b0;
    riscv_isa_pkg::word_t instr;
    logic                 if_valid = 1'b1;
    riscv_isa_pkg::word_t pc_out;
    riscv_isa_pkg::word_t data_in;
    logic                 mem_valid = 1'b1;
    riscv_isa_pkg::word_t data_addr;
    riscv_isa_pkg::word_t data_out;
    logic                 data_we;
    logic [3:0]           data_be;

    riscv_isa_pkg::word_t stim [128];
    riscv_isa_pkg::word_t imem [IMEM_WORDS];
    riscv_isa_pkg::word_t dmem [64];
    riscv_isa_pkg::word_t exp_addr;
    logic [31:0]          rng_state = 32'd90691;
    logic                 stall_en = 1'b0;
    logic                 setup_ok = 1'b0;
    int prog_len = 0;
    int exp_count = 0;
    int cycle_limit = 0;
    int store_idx = 0;
    int errors = 0;
    int timeouts = 0;
    int fill_idx;
    int lane;

    pineapple_core dut0 (
        .clk(clk), .arst_n(arst_n), .instr(instr), .if_valid(if_valid), .pc_out(pc_out),
        .data_in(data_in), .mem_valid(mem_valid), .data_addr(data_addr),
        .data_out(data_out), .data_we(data_we), .data_be(data_be)
    );

    // Both memories answer combinationally
    assign instr   = (pc_out[31:8] == '0) ? imem[pc_out[7:2]] : NOP;
    assign data_in = dmem[data_addr[7:2]];

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare(input string what, input logic [31:0] got,
                           input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // Each side low about a quarter of the time
    always @(posedge clk) begin
        #10;
        rng_state = xorshift32(rng_state);
        if_valid  = !stall_en || (rng_state[1:0] != 2'b00);
        mem_valid = !stall_en || (rng_state[9:8] != 2'b00);
    end

    // Data memory model and in-order store check
    always @(negedge clk) begin
        if (!arst_n) begin
            for (fill_idx = 0; fill_idx < 64; fill_idx++)
                dmem[fill_idx] = 32'hC0DE_0000 | (fill_idx << 2);
            store_idx = 0;
            compare("pc_out in reset", pc_out, '0);
            compare("data_we in reset", 32'(data_we), '0);
            compare("data_be in reset", 32'(data_be), '0);
        end else if (data_we) begin
            if (store_idx < exp_count) begin
                exp_addr = stim[EXP_BASE + 1 + 2 * store_idx];
                compare("store address", data_addr, exp_addr);
                compare("store data", data_out, stim[EXP_BASE + 2 + 2 * store_idx]);
                // Unaligned stores are bytes on their own lane
                if (exp_addr[1:0] != 2'b00 || data_be != 4'b1111)
                    compare("store byte enable", 32'(data_be), 32'(4'b0001 << exp_addr[1:0]));
            end else begin
                errors++;
                $display("Store to %h came after the last expected store", data_addr);
            end
            store_idx++;
            for (lane = 0; lane < 4; lane++)
                if (data_be[lane])
                    dmem[data_addr[7:2]][8 * lane +: 8] = data_out[8 * lane +: 8];
        end
    end

    task automatic run_program(input logic random_stalls);
        int cycles;
        stall_en = random_stalls;
        #10 arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #10 arst_n = 1'b1;
        cycles = 0;
        while (store_idx < exp_count && cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (store_idx < exp_count) begin
            timeouts++;
            $display("Timeout after %0d cycles: program did not finish, %0d of %0d stores seen",
                     cycles, store_idx, exp_count);
        end else begin
            // Drain so that stray stores show up
            repeat (20) @(posedge clk);
        end
    endtask

    initial begin
        int idx;
        for (idx = 0; idx < 128; idx++)
            stim[idx] = '0;
        $readmemh("tests/program_stim.txt", stim);
        while (prog_len < IMEM_WORDS && stim[prog_len] != '0)
            prog_len++;
        for (idx = 0; idx < IMEM_WORDS; idx++)
            imem[idx] = (idx < prog_len) ? stim[idx] : NOP;
        exp_count   = int'(stim[EXP_BASE]);
        cycle_limit = 20 * prog_len + 200;
        setup_ok    = (prog_len > 0) && (exp_count > 0);
        if (!setup_ok) begin
            $display("No program or store list read from tests/program_stim.txt");
        end else begin
            run_program(1'b0);
            if (timeouts == 0)
                run_program(1'b1);
        end
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (setup_ok && errors == 0 && timeouts == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule
